// File: verilog/gamePkg.sv
`default_nettype none

package gamePkg;

	// ------------------------------------------------
	// fixed point and geometry
	// ------------------------------------------------
	localparam int fracBits = 6;          // 1/64 pixel resolution
	localparam int fixedOne = 64;         // one pixel in fixed point
	localparam int coordBits = 11;        // signed pixel coordinate width
	localparam int objectSize = 32;       // player box and tile size

	localparam int screenWidth = 640;
	localparam int screenHeight = 480;

	// playfield limits for the top-left corner, in pixels
	localparam int frameLeft = 15;
	localparam int frameRight = 623 - objectSize;
	localparam int frameTop = 48;
	localparam int frameBottom = 464 - objectSize;

	// one-hot sprite edge codes
	localparam logic [3:0] edgeTop = 4'b1000;
	localparam logic [3:0] edgeRight = 4'b0100;
	localparam logic [3:0] edgeLeft = 4'b0010;
	localparam logic [3:0] edgeBottom = 4'b0001;

	// per-frame step per speed level, level 3 repeats level 2
	localparam logic [0:3][7:0] speedStep = '{8'd64, 8'd112, 8'd160, 8'd160};

	// position word, summed as raw, split into pixel and fraction for output
	typedef union packed {
		logic signed [coordBits+fracBits-1:0] raw;
		struct packed {
			logic signed [coordBits-1:0] pixel;
			logic [fracBits-1:0] frac;  // sub-pixel remainder, carried between frames
		} parts;
	} fixPos_t;

	// ------------------------------------------------
	// wall tiles, row by row, column 0 on the left
	// ------------------------------------------------
	// top row sits above the playfield; off-screen also reads as wall (mazeMap)
	localparam logic [0:14][0:19] wallTiles = '{
		20'b11111_11111_11111_11111,  // row 0
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_10000_00000,  // row 5, column at tile 10 starts
		20'b00000_00000_10000_00000,
		20'b00000_00000_10000_00000,
		20'b00000_00000_10000_00000,  // row 8, last row of the column
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000,
		20'b00000_00000_00000_00000   // row 14
	};

endpackage

`default_nettype wire

// File: verilog/keyPad.sv
`default_nettype none

module keyPad (
	input  logic clk,
	input  logic resetN,
	input  logic upKey,      // raw asynchronous key levels
	input  logic downKey,
	input  logic leftKey,
	input  logic rightKey,
	output logic dirUp,      // one-hot direction, at most one high
	output logic dirDown,
	output logic dirLeft,
	output logic dirRight
);

	logic [3:0] keyMeta;  // first stage, may go metastable
	logic [3:0] keySync;  // second stage, safe to use

	// ------------------------------------------------
	// two-flop synchronizer, bit order up down left right
	// ------------------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			keyMeta <= 4'b0000;
			keySync <= 4'b0000;
		end else begin
			keyMeta <= {upKey, downKey, leftKey, rightKey};
			keySync <= keyMeta;
		end
	end

	// fixed priority up > down > left > right
	// so the motion FSM never sees a diagonal
	assign dirUp = keySync[3];
	assign dirDown = keySync[2] & ~keySync[3];
	assign dirLeft = keySync[1] & ~|keySync[3:2];
	assign dirRight = keySync[0] & ~|keySync[3:1];

endmodule

`default_nettype wire

// File: verilog/mazeMap.sv
`default_nettype none

module mazeMap import gamePkg::*; (
	input  logic signed [10:0] candX,   // proposed top-left of the player box
	input  logic signed [10:0] candY,
	input  logic signed [10:0] pixelX,  // current video pixel
	input  logic signed [10:0] pixelY,
	output logic validPlayerPos,        // box at cand is clear of walls
	output logic wallPixel              // pixel lies in a wall tile
);

	localparam int edgeOffset = objectSize - 1;     // far corner offset in the box
	localparam int tileShift = $clog2(objectSize);  // 5, pixel to tile index

	logic signed [10:0] candRight;   // right column of the proposed box
	logic signed [10:0] candBottom;  // bottom row of the proposed box

	// wall lookup for one point
	// anything off the 640x480 screen counts as wall
	function automatic logic isWall(input logic signed [10:0] x, input logic signed [10:0] y);
		if (x < 0 || x >= screenWidth || y < 0 || y >= screenHeight)
			return 1'b1;
		return wallTiles[y[8:tileShift]][x[9:tileShift]];  // row 0..14, column 0..19
	endfunction

	assign candRight = 11'(candX + edgeOffset);
	assign candBottom = 11'(candY + edgeOffset);

	// ------------------------------------------------
	// clearance query, four corners of the box
	// ------------------------------------------------
	// box and tile are the same size, so no wall can
	// hide between two corners
	assign validPlayerPos = !(isWall(candX, candY) |
		isWall(candRight, candY) |
		isWall(candX, candBottom) |
		isWall(candRight, candBottom));

	assign wallPixel = isWall(pixelX, pixelY);  // single pixel query for collision

endmodule

`default_nettype wire

// File: verilog/playerMove.sv
`default_nettype none

module playerMove import gamePkg::*; #(
	parameter int initialX = 15,  // start position in pixels
	parameter int initialY = 48
) (
	input  logic clk,
	input  logic resetN,
	input  logic startOfFrame,       // one-cycle pulse per frame
	input  logic dirUp,
	input  logic dirDown,
	input  logic dirLeft,
	input  logic dirRight,
	input  logic validPlayerPos,     // answer to the candX/candY query
	input  logic wallHit,            // player pixel on a wall this cycle
	input  logic [3:0] hitEdge,      // which sprite edge the hit is on
	input  logic [1:0] speedLevel,
	output logic signed [10:0] topLeftX,
	output logic signed [10:0] topLeftY,
	output logic signed [10:0] candX,
	output logic signed [10:0] candY,
	output logic [1:0] currentSpeedLevel
);

	// playfield limits in fixed point
	localparam logic signed [16:0] xMin = 17'(frameLeft * fixedOne);
	localparam logic signed [16:0] xMax = 17'(frameRight * fixedOne);
	localparam logic signed [16:0] yMin = 17'(frameTop * fixedOne);
	localparam logic signed [16:0] yMax = 17'(frameBottom * fixedOne);
	localparam logic signed [16:0] bounce = 17'(fixedOne);  // one pixel push

	typedef enum logic [2:0] {
		idleSt,       // wait for the first frame and load the start position
		moveSt,       // latch a step and collect collisions
		validSt,      // sample the wall clearance of the candidate
		sofSt,        // decode collected hits into a bounce
		posChangeSt,  // apply the move
		limitsSt      // clamp to the playfield
	} motionState_t;

	motionState_t state;

	fixPos_t xPos;       // current position
	fixPos_t yPos;
	fixPos_t candPosX;   // position the step would lead to
	fixPos_t candPosY;

	logic signed [16:0] xMove;     // pending move for this frame
	logic signed [16:0] yMove;
	logic signed [16:0] stepSize;
	logic signed [16:0] bounceX;
	logic signed [16:0] bounceY;
	logic [3:0] hitReg;            // edges hit during the frame
	logic moveFlag;                // step latched this frame
	logic checked;                 // clearance already asked this frame

	assign stepSize = 17'(speedStep[currentSpeedLevel]);

	// ------------------------------------------------
	// push away from the touched side on a hit
	// ------------------------------------------------
	always_comb begin
		bounceX = '0;
		bounceY = '0;
		case (hitReg)
			edgeTop | edgeLeft: begin      // top-left corner
				bounceX = bounce;
				bounceY = bounce;
			end
			edgeTop | edgeRight: begin     // top-right corner
				bounceX = -bounce;
				bounceY = bounce;
			end
			edgeBottom | edgeLeft: begin   // bottom-left corner
				bounceX = bounce;
				bounceY = -bounce;
			end
			edgeBottom | edgeRight: begin  // bottom-right corner
				bounceX = -bounce;
				bounceY = -bounce;
			end
			edgeTop: bounceY = bounce;
			edgeBottom: bounceY = -bounce;
			edgeLeft: bounceX = bounce;
			edgeRight: bounceX = -bounce;
			default: ;  // no push for no hit or an odd mix
		endcase
	end

	// ------------------------------------------------
	// motion FSM
	// ------------------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= idleSt;
			xPos.raw <= '0;
			yPos.raw <= '0;
			candPosX.raw <= '0;
			candPosY.raw <= '0;
			xMove <= '0;
			yMove <= '0;
			hitReg <= 4'b0000;
			moveFlag <= 1'b0;
			checked <= 1'b0;
			currentSpeedLevel <= 2'd0;
		end else begin
			if (wallHit && (state == moveSt || state == validSt))
				hitReg <= hitReg | hitEdge;  // gather over the whole frame

			case (state)
				idleSt: begin
					if (startOfFrame) begin  // first frame only places the player
						xPos.raw <= 17'(initialX * fixedOne);
						yPos.raw <= 17'(initialY * fixedOne);
						state <= moveSt;
					end
				end

				moveSt: begin
					if (startOfFrame) begin
						if (!checked) begin  // step without a clearance answer is dropped
							xMove <= '0;
							yMove <= '0;
						end
						moveFlag <= 1'b0;
						checked <= 1'b0;
						state <= sofSt;
					end else if (!moveFlag) begin
						moveFlag <= dirUp | dirDown | dirLeft | dirRight;
						if (dirUp)
							yMove <= -stepSize;
						else if (dirDown)
							yMove <= stepSize;
						else if (dirLeft)
							xMove <= -stepSize;
						else if (dirRight)
							xMove <= stepSize;
					end else if (!checked) begin  // one cycle after the latch
						candPosX.raw <= xPos.raw + xMove;
						candPosY.raw <= yPos.raw + yMove;
						checked <= 1'b1;
						state <= validSt;
					end
				end

				validSt: begin
					if (!validPlayerPos) begin  // drop the step when blocked
						xMove <= '0;
						yMove <= '0;
					end
					if (startOfFrame) begin
						moveFlag <= 1'b0;
						checked <= 1'b0;
						state <= sofSt;
					end else
						state <= moveSt;
				end

				sofSt: begin
					xMove <= xMove + bounceX;
					yMove <= yMove + bounceY;
					hitReg <= 4'b0000;
					state <= posChangeSt;
				end

				posChangeSt: begin
					xPos.raw <= xPos.raw + xMove;  // fraction carries over
					yPos.raw <= yPos.raw + yMove;
					xMove <= '0;
					yMove <= '0;
					currentSpeedLevel <= speedLevel;  // new step size from next frame
					state <= limitsSt;
				end

				limitsSt: begin
					if (xPos.raw < xMin)
						xPos.raw <= xMin;
					else if (xPos.raw > xMax)
						xPos.raw <= xMax;
					if (yPos.raw < yMin)
						yPos.raw <= yMin;
					else if (yPos.raw > yMax)
						yPos.raw <= yMax;
					state <= moveSt;
				end

				default: state <= idleSt;
			endcase
		end
	end

	// outputs carry the pixel part only
	assign topLeftX = xPos.parts.pixel;
	assign topLeftY = yPos.parts.pixel;
	assign candX = candPosX.parts.pixel;
	assign candY = candPosY.parts.pixel;

endmodule

`default_nettype wire

// File: verilog/playerDraw.sv
`default_nettype none

module playerDraw import gamePkg::*; (
	input  logic signed [10:0] pixelX,    // current video pixel
	input  logic signed [10:0] pixelY,
	input  logic signed [10:0] topLeftX,  // player box corner
	input  logic signed [10:0] topLeftY,
	input  logic wallPixel,               // pixel is in a wall tile
	output logic drawPlayer,
	output logic wallHit,
	output logic [3:0] hitEdge
);

	localparam int edgeOffset = objectSize - 1;

	logic signed [10:0] rightCol;   // last column of the box
	logic signed [10:0] bottomRow;  // last row of the box
	logic placed;                   // box has been put on the playfield

	assign rightCol = 11'(topLeftX + edgeOffset);
	assign bottomRow = 11'(topLeftY + edgeOffset);

	// position sits at 0,0 until the first frame places it
	assign placed = (topLeftX >= frameLeft) && (topLeftY >= frameTop);

	// ------------------------------------------------
	// box test and edge coding
	// ------------------------------------------------
	assign drawPlayer = placed &&
		pixelX >= topLeftX && pixelX <= rightCol &&
		pixelY >= topLeftY && pixelY <= bottomRow;

	always_comb begin
		hitEdge = 4'b0000;  // interior or outside
		if (drawPlayer) begin
			if (pixelY == topLeftY)
				hitEdge = edgeTop;     // rows win over columns at the corners
			else if (pixelY == bottomRow)
				hitEdge = edgeBottom;
			else if (pixelX == topLeftX)
				hitEdge = edgeLeft;
			else if (pixelX == rightCol)
				hitEdge = edgeRight;
		end
	end

	// only the outline of the sprite reports a collision
	assign wallHit = drawPlayer && wallPixel && (hitEdge != 4'b0000);

endmodule

`default_nettype wire

// File: verilog/playerTop.sv
`default_nettype none

module playerTop #(
	parameter int initialX = 15,
	parameter int initialY = 48
) (
	input  logic clk,
	input  logic resetN,
	input  logic startOfFrame,
	input  logic upKey,
	input  logic downKey,
	input  logic leftKey,
	input  logic rightKey,
	input  logic [1:0] speedLevel,        // from a pin, no power-ups here
	input  logic signed [10:0] pixelX,
	input  logic signed [10:0] pixelY,
	output logic signed [10:0] topLeftX,
	output logic signed [10:0] topLeftY,
	output logic drawPlayer,
	output logic [1:0] currentSpeedLevel
);

	logic dirUp;
	logic dirDown;
	logic dirLeft;
	logic dirRight;
	logic signed [10:0] candX;    // clearance query
	logic signed [10:0] candY;
	logic validPlayerPos;
	logic wallPixel;              // pixel query answer
	logic wallHit;
	logic [3:0] hitEdge;

	// ------------------------------------------------
	// input side
	// ------------------------------------------------
	keyPad i_keyPad (
		.clk(clk),
		.resetN(resetN),
		.upKey(upKey),
		.downKey(downKey),
		.leftKey(leftKey),
		.rightKey(rightKey),
		.dirUp(dirUp),
		.dirDown(dirDown),
		.dirLeft(dirLeft),
		.dirRight(dirRight)
	);

	// ------------------------------------------------
	// motion and tile map
	// ------------------------------------------------
	playerMove #(
		.initialX(initialX),
		.initialY(initialY)
	) i_playerMove (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.dirUp(dirUp),
		.dirDown(dirDown),
		.dirLeft(dirLeft),
		.dirRight(dirRight),
		.validPlayerPos(validPlayerPos),
		.wallHit(wallHit),
		.hitEdge(hitEdge),
		.speedLevel(speedLevel),
		.topLeftX(topLeftX),
		.topLeftY(topLeftY),
		.candX(candX),
		.candY(candY),
		.currentSpeedLevel(currentSpeedLevel)
	);

	mazeMap i_mazeMap (
		.candX(candX),
		.candY(candY),
		.pixelX(pixelX),  // same pixel the draw side tests
		.pixelY(pixelY),
		.validPlayerPos(validPlayerPos),
		.wallPixel(wallPixel)
	);

	// ------------------------------------------------
	// output side
	// ------------------------------------------------
	playerDraw i_playerDraw (
		.pixelX(pixelX),
		.pixelY(pixelY),
		.topLeftX(topLeftX),
		.topLeftY(topLeftY),
		.wallPixel(wallPixel),
		.drawPlayer(drawPlayer),
		.wallHit(wallHit),
		.hitEdge(hitEdge)
	);

endmodule

`default_nettype wire

// File: tb/playerMove_properties.sv
`default_nettype none

module playerMoveProperties import gamePkg::*; (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic signed [10:0] topLeftX,
	input logic signed [10:0] topLeftY,
	input logic [1:0] currentSpeedLevel
);
	timeunit 1ns;
	timeprecision 1ps;

	// ------------------------------------------------
	// position is final 4 cycles after startOfFrame
	// ------------------------------------------------
	insideFrame: assert property (@(posedge clk) disable iff (!resetN)
		$past(startOfFrame, 4) |->
			(topLeftX >= frameLeft && topLeftX <= frameRight &&
			topLeftY >= frameTop && topLeftY <= frameBottom))
		else $error("position outside the playfield after clamp");

	// first frame jumps from 0 to the start position, skip it
	smallStep: assert property (@(posedge clk) disable iff (!resetN)
		($past(startOfFrame, 4) && $past(topLeftX, 4) != 0) |->
			((topLeftX - $past(topLeftX, 4)) <= 3 && (topLeftX - $past(topLeftX, 4)) >= -3 &&
			(topLeftY - $past(topLeftY, 4)) <= 3 && (topLeftY - $past(topLeftY, 4)) >= -3))
		else $error("position jumped more than 3 pixels in one frame");

	speedOnFrame: assert property (@(posedge clk) disable iff (!resetN)
		$changed(currentSpeedLevel) |-> $past(startOfFrame, 3))
		else $error("speed level changed outside the frame update");

endmodule

bind playerMove playerMoveProperties i_playerMoveProperties (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.topLeftX(topLeftX),
	.topLeftY(topLeftY),
	.currentSpeedLevel(currentSpeedLevel)
);

`default_nettype wire

// File: tb/playerTb.sv
`default_nettype none

module playerTb import gamePkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int startX = 290;       // box overlaps the wall column on purpose
	localparam int startY = 140;
	localparam int clkPeriod = 40;
	localparam int frameBudget = 220;  // upper bound on frames over all tests

	logic clk;
	logic resetN;
	logic startOfFrame;
	logic upKey;
	logic downKey;
	logic leftKey;
	logic rightKey;
	logic [1:0] speedLevel;
	logic signed [10:0] pixelX;
	logic signed [10:0] pixelY;
	logic signed [10:0] topLeftX;
	logic signed [10:0] topLeftY;
	logic drawPlayer;
	logic [1:0] currentSpeedLevel;

	// reference model in 1/64 pixel units
	int modelX;
	int modelY;
	int pendX;         // step waiting for the next frame
	int pendY;
	int bumpX;         // expected bounce from collected hits
	int bumpY;
	int modelLevel;
	bit modelPlaced;
	int seed;

	playerTop #(
		.initialX(startX),
		.initialY(startY)
	) i_playerTop (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.upKey(upKey),
		.downKey(downKey),
		.leftKey(leftKey),
		.rightKey(rightKey),
		.speedLevel(speedLevel),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.topLeftX(topLeftX),
		.topLeftY(topLeftY),
		.drawPlayer(drawPlayer),
		.currentSpeedLevel(currentSpeedLevel)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// watchdog allows 14 cycles per frame plus slack
	initial begin
		#((frameBudget * 14 + 50) * clkPeriod);
		$display("timeout, the run did not finish within the frame budget");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	task automatic checkValue(input string name, input int got, input int expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %0h expected %0h", name, got, expected);
			$display("Test failed");
			$fatal(1, "check failed");
		end
	endtask

	function automatic bit tileWall(input int x, input int y);
		if (x < 0 || x >= 640 || y < 0 || y >= 480)
			return 1'b1;  // off screen
		return wallTiles[y / objectSize][x / objectSize];
	endfunction

	function automatic bit boxClear(input int x, input int y);
		return !(tileWall(x, y) || tileWall(x + 31, y) ||
			tileWall(x, y + 31) || tileWall(x + 31, y + 31));
	endfunction

	// one model frame applies the pending move and bounce, clamps and latches the next step
	task automatic advanceModel();
		int step;
		if (!modelPlaced) begin
			modelX = startX * fixedOne;
			modelY = startY * fixedOne;
			modelPlaced = 1'b1;
		end else begin
			modelX = modelX + pendX + bumpX;
			modelY = modelY + pendY + bumpY;
			bumpX = 0;
			bumpY = 0;
			if (modelX < frameLeft * fixedOne) modelX = frameLeft * fixedOne;
			if (modelX > frameRight * fixedOne) modelX = frameRight * fixedOne;
			if (modelY < frameTop * fixedOne) modelY = frameTop * fixedOne;
			if (modelY > frameBottom * fixedOne) modelY = frameBottom * fixedOne;
			modelLevel = int'(speedLevel);
		end
		pendX = 0;
		pendY = 0;
		step = int'(speedStep[modelLevel]);
		if (upKey) pendY = -step;  // up > down > left > right
		else if (downKey) pendY = step;
		else if (leftKey) pendX = -step;
		else if (rightKey) pendX = step;
		if ((pendX != 0 || pendY != 0) &&
			!boxClear((modelX + pendX) / fixedOne, (modelY + pendY) / fixedOne)) begin
			pendX = 0;
			pendY = 0;
		end
	endtask

	task automatic runFrame();
		@(posedge clk);
		#5 startOfFrame = 1'b1;
		@(posedge clk);
		#5 startOfFrame = 1'b0;
		repeat (11) @(posedge clk);
		#5;
		advanceModel();
	endtask

	task automatic checkPos();
		checkValue("topLeftX", int'(topLeftX), modelX / fixedOne);
		checkValue("topLeftY", int'(topLeftY), modelY / fixedOne);
		checkValue("currentSpeedLevel", int'(currentSpeedLevel), modelLevel);
	endtask

	task automatic setKeys(input bit u, input bit d, input bit l, input bit r);
		upKey = u;
		downKey = d;
		leftKey = l;
		rightKey = r;
	endtask

	// ------------------------------------------------
	// directed tests
	// ------------------------------------------------
	task automatic resetAndStart();
		checkValue("topLeftX", int'(topLeftX), 0);
		checkValue("topLeftY", int'(topLeftY), 0);
		checkValue("currentSpeedLevel", int'(currentSpeedLevel), 0);
		checkValue("drawPlayer", int'(drawPlayer), 0);
		runFrame();
		checkValue("topLeftX", int'(topLeftX), startX);
		checkValue("topLeftY", int'(topLeftY), startY);
		checkPos();
	endtask

	// right edge column sits in the wall and two pushes clear it
	task automatic collisionBounce();
		int expectX;
		repeat (2) begin
			pixelX = 11'(topLeftX + 31);
			pixelY = 11'(topLeftY + 25);  // not a corner row
			repeat (2) @(posedge clk);
			#5;
			pixelX = '0;
			pixelY = '0;
			expectX = modelX / fixedOne - 1;
			bumpX = -fixedOne;
			runFrame();
			checkValue("topLeftX", int'(topLeftX), expectX);
			checkPos();
		end
	endtask

	task automatic wallValidity();
		speedLevel = 2'd0;
		setKeys(0, 0, 0, 1);
		repeat (3) begin
			runFrame();
			checkPos();
			checkValue("topLeftX", int'(topLeftX), startX - 2);  // step into wall dropped
		end
	endtask

	task automatic steppingAndSpeed();
		int prevX;
		int prevY;
		setKeys(0, 0, 1, 0);
		runFrame();  // applies the dropped step and latches left
		checkPos();
		repeat (3) begin
			prevX = modelX / fixedOne;
			runFrame();
			checkPos();
			checkValue("left step", prevX - int'(topLeftX), 1);
		end
		speedLevel = 2'd2;
		prevX = modelX / fixedOne;
		runFrame();  // old step still pending
		checkPos();
		checkValue("left step", prevX - int'(topLeftX), 1);
		repeat (4) begin
			runFrame();
			checkPos();
		end
		setKeys(1, 0, 1, 0);  // up wins over left
		runFrame();
		checkPos();
		prevX = modelX / fixedOne;
		prevY = modelY / fixedOne;
		repeat (2) begin
			runFrame();
			checkPos();
			checkValue("topLeftX", int'(topLeftX), prevX);
		end
		checkValue("moved up", int'(topLeftY < prevY), 1);
	endtask

	task automatic frameClamp();
		setKeys(0, 0, 1, 0);
		repeat (120) begin
			runFrame();
			checkPos();
			checkValue("below left limit", int'(topLeftX < frameLeft), 0);
		end
		checkValue("topLeftX", int'(topLeftX), frameLeft);
		setKeys(1, 0, 0, 0);
		repeat (40) begin
			runFrame();
			checkPos();
			checkValue("above top limit", int'(topLeftY < frameTop), 0);
		end
		checkValue("topLeftY", int'(topLeftY), frameTop);
	endtask

	task automatic randomSequence();
		logic [31:0] r;
		repeat (20) begin
			r = $random(seed);
			setKeys(r[0], r[1], r[2], r[3]);
			speedLevel = r[5:4];
			runFrame();
			checkPos();
			pixelX = topLeftX;  // top-left pixel of the box
			pixelY = topLeftY;
			#1 checkValue("drawPlayer", int'(drawPlayer), 1);
			pixelX = 11'(topLeftX - 1);  // one column outside
			#1 checkValue("drawPlayer", int'(drawPlayer), 0);
			pixelX = '0;
			pixelY = '0;
		end
		setKeys(0, 0, 0, 0);
	endtask

	initial begin
		clk = 1'b0;
		resetN = 1'b0;
		startOfFrame = 1'b0;
		setKeys(0, 0, 0, 0);
		speedLevel = 2'd0;
		pixelX = '0;  // parked on the border wall far from the player
		pixelY = '0;
		modelX = 0;
		modelY = 0;
		pendX = 0;
		pendY = 0;
		bumpX = 0;
		bumpY = 0;
		modelLevel = 0;
		modelPlaced = 1'b0;
		seed = 32'h1993f948;
		repeat (2) @(posedge clk);
		#5 resetN = 1'b1;

		resetAndStart();
		collisionBounce();
		wallValidity();
		steppingAndSpeed();
		frameClamp();
		randomSequence();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/gamePkg.sv
verilog/keyPad.sv
verilog/mazeMap.sv
verilog/playerMove.sv
verilog/playerDraw.sv
verilog/playerTop.sv
tb/playerMove_properties.sv
tb/playerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= playerTb
OBJDIR ?= obj_dir
LOG ?= sim.log
FLIST ?= flist.f
VFLAGS ?= --binary --assert --timing

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
